/* verilog.f */
src/rvPkg.sv
src/regFile.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memWriteback.sv
src/hazardUnit.sv
src/rvPipelineTop.sv
tb/rvPipeline_assertions.sv
tb/rvPipelineTb.sv

/* Bender.yml */
package:
  name: rv_pipeline

sources:
  - src/rvPkg.sv
  - src/regFile.sv
  - src/fetchStage.sv
  - src/decodeStage.sv
  - src/executeStage.sv
  - src/memWriteback.sv
  - src/hazardUnit.sv
  - src/rvPipelineTop.sv
  - target: test
    files:
      - tb/rvPipeline_assertions.sv
      - tb/rvPipelineTb.sv

/* tb/rvPipelineTb.sv */
module rvPipelineTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clkPeriod     = 8;
  localparam int resetCycles   = 16;
  localparam int directedLen   = 40;
  localparam int numRandom     = 40;
  localparam int progLen       = directedLen + numRandom;
  localparam int watchdogCycles = progLen * 6 + resetCycles;
  localparam logic [31:0] nopWord  = 32'h0000_0013; // addi x0, x0, 0
  localparam logic [31:0] lfsrTaps = 32'hB4BC_D35C;

  logic                   CLK;
  logic                   RESET;
  rvPkg::instrT           fetchInstr;
  logic [rvPkg::xlen-1:0] fetchAddr;
  rvPkg::retireT          retire;

  logic [31:0]   prog [progLen];
  int            progCount;
  logic [31:0]   lfsr;
  rvPkg::retireT expected [$];
  int            expectedTotal;
  int            retireCount;
  int            valueErrors;
  int            otherErrors;
  int            afterReset;

  rvPipelineTop uut (
    .CLK        (CLK),
    .RESET      (RESET),
    .fetchInstr (fetchInstr),
    .fetchAddr  (fetchAddr),
    .retire     (retire)
  );

  initial CLK = 1'b0;
  always #(clkPeriod / 2) CLK = ~CLK;

  // instruction memory reads nops past the program
  assign fetchInstr = (fetchAddr[31:2] < progLen) ? prog[fetchAddr[31:2]] : nopWord;

  // ============================================================
  // instruction encoders and random source
  // ============================================================
  function automatic logic [31:0] regOp(input logic [2:0] f3, input logic alt,
                                        input logic [4:0] rd, rs1, rs2);
    return {(alt ? 7'b0100000 : 7'b0000000), rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] immOp(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] loadWord(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] storeWord(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branchEq(input logic [4:0] rs1, rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] loadUpper(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] jumpLink(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ lfsrTaps) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] bits;
    int          i;
    bits = '0;
    for (i = 0; i < count; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsrStep(lfsr);
    end
    return bits;
  endfunction

  function automatic void emit(input logic [31:0] word);
    prog[progCount] = word;
    progCount++;
  endfunction

  task automatic buildProgram();
    logic [1:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    int          i;
    progCount = 0;
    emit(loadUpper(1, 20'h12345));
    emit(immOp(3'b000, 1, 1, 12'h678));  // mem forward
    emit(immOp(3'b000, 2, 0, 12'hffb));  // -5
    emit(regOp(3'b000, 0, 3, 1, 2));     // wb and mem forward
    emit(regOp(3'b000, 1, 4, 3, 1));
    emit(regOp(3'b111, 0, 5, 1, 2));
    emit(regOp(3'b110, 0, 6, 1, 2));
    emit(regOp(3'b100, 0, 7, 1, 2));
    emit(regOp(3'b010, 0, 8, 2, 1));     // signed compare
    emit(regOp(3'b011, 0, 9, 2, 1));
    emit(immOp(3'b000, 10, 0, 12'h004));
    emit(regOp(3'b001, 0, 11, 1, 10));
    emit(regOp(3'b101, 0, 12, 2, 10));
    emit(regOp(3'b101, 1, 13, 2, 10));
    emit(immOp(3'b001, 14, 1, 12'h003));
    emit(immOp(3'b101, 15, 2, 12'h01c));
    emit(immOp(3'b101, 16, 2, 12'h401)); // srai
    emit(immOp(3'b010, 17, 2, 12'hfff));
    emit(immOp(3'b011, 18, 1, 12'hfff));
    emit(immOp(3'b100, 19, 1, 12'h0ff));
    emit(immOp(3'b110, 20, 2, 12'h100));
    emit(immOp(3'b111, 21, 1, 12'h7f0));
    emit(immOp(3'b000, 0, 1, 12'h001));  // x0 target never retires
    emit(regOp(3'b000, 0, 22, 0, 1));
    emit(storeWord(1, 10, 12'h008));
    emit(loadWord(23, 0, 12'h00c));
    emit(regOp(3'b000, 0, 24, 23, 2));   // load-use
    emit(storeWord(3, 0, 12'h010));
    emit(loadWord(25, 10, 12'h00c));
    emit(immOp(3'b000, 26, 25, 12'h001));
    emit(branchEq(1, 22, 13'd12));       // taken
    emit(immOp(3'b000, 27, 0, 12'h001));
    emit(immOp(3'b000, 28, 0, 12'h002));
    emit(immOp(3'b000, 29, 0, 12'h003));
    emit(branchEq(1, 2, 13'd8));         // falls through
    emit(immOp(3'b000, 30, 0, 12'h005));
    emit(jumpLink(31, 21'd12));
    emit(immOp(3'b000, 27, 0, 12'h007));
    emit(immOp(3'b000, 28, 0, 12'h008));
    emit(regOp(3'b000, 0, 5, 31, 30));
    // ============================================================
    // random alu section on x0..x7
    // ============================================================
    for (i = 0; i < numRandom; i++) begin
      kind = 2'(randomBits(2));
      rd   = 5'(randomBits(3));
      rs1  = 5'(randomBits(3));
      rs2  = 5'(randomBits(3));
      f3   = 3'(randomBits(3));
      alt  = 1'(randomBits(1));
      imm  = 12'(randomBits(12));
      if (kind == 2'd3) begin
        emit(loadUpper(rd, 20'(randomBits(20))));
      end else if (kind == 2'd2) begin
        if (f3 == 3'b001) imm = {7'b0, imm[4:0]};
        else if (f3 == 3'b101) imm = {1'b0, alt, 5'b0, imm[4:0]};
        emit(immOp(f3, rd, rs1, imm));
      end else begin
        emit(regOp(f3, alt && (f3 == 3'b000 || f3 == 3'b101), rd, rs1, rs2));
      end
    end
  endtask

  // ============================================================
  // isa reference model
  // ============================================================
  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic void buildExpected();
    logic [31:0]   x [32];
    logic [31:0]   dmem [128];
    logic [31:0]   pc;
    logic [31:0]   nextPc;
    logic [31:0]   ins;
    logic [31:0]   a;
    logic [31:0]   b;
    logic [31:0]   addr;
    logic [31:0]   res;
    logic          writes;
    rvPkg::retireT entry;
    int            steps;
    x = '{default: '0};
    pc = '0;
    steps = 0;
    while (pc < progLen * 4 && steps < progLen * 4) begin
      ins    = prog[pc[31:2]];
      a      = x[ins[19:15]];
      b      = x[ins[24:20]];
      nextPc = pc + 4;
      writes = 1'b1;
      res    = '0;
      case (ins[6:0])
        7'b0110011: res = aluRef(ins[14:12], ins[30], a, b);
        7'b0010011: res = aluRef(ins[14:12], ins[30] && (ins[14:12] == 3'b101), a,
                                 {{20{ins[31]}}, ins[31:20]});
        7'b0000011: begin
          addr = a + {{20{ins[31]}}, ins[31:20]};
          res  = dmem[addr[8:2]];
        end
        7'b0100011: begin
          writes = 1'b0;
          addr   = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          dmem[addr[8:2]] = b;
        end
        7'b0110111: res = {ins[31:12], 12'b0};
        7'b1100011: begin
          writes = 1'b0;
          if (a == b) nextPc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        7'b1101111: begin
          res    = pc + 4;
          nextPc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        default: writes = 1'b0;
      endcase
      if (writes && ins[11:7] != 5'd0) begin
        x[ins[11:7]] = res;
        entry.valid  = 1'b1;
        entry.rd     = ins[11:7];
        entry.value  = res;
        expected.push_back(entry);
      end
      pc = nextPc;
      steps++;
    end
  endfunction

  task automatic finishRun();
    if (expected.size() != 0) begin
      otherErrors += expected.size();
      $display("%0d expected register writes never retired", expected.size());
    end
    if (uut.checks.failCount != 0) begin
      otherErrors += uut.checks.failCount;
      $display("%0d bound assertion checks failed", uut.checks.failCount);
    end
    $display("retires %0d of %0d expected, value errors %0d, other errors %0d",
             retireCount, expectedTotal, valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // ============================================================
  // stimulus, comparison and watchdog
  // ============================================================
  initial begin
    RESET       = 1'b1;
    lfsr        = 32'd71;
    retireCount = 0;
    valueErrors = 0;
    otherErrors = 0;
    buildProgram();
    if (progCount != progLen) begin
      otherErrors++;
      $display("program builder placed %0d words instead of %0d", progCount, progLen);
    end
    buildExpected();
    expectedTotal = expected.size();
    repeat (resetCycles) @(posedge CLK);
    RESET <= 1'b0;
    while (expected.size() != 0) @(negedge CLK);
    repeat (8) @(negedge CLK); // catch stray retires
    finishRun();
  end

  always @(negedge CLK) begin
    rvPkg::retireT want;
    if (RESET) afterReset = 0;
    else afterReset++;
    if (retire.valid === 1'b1) begin
      if (RESET || afterReset <= 4) begin
        otherErrors++;
        $display("retire at %0t came during reset or too soon after it", $time);
      end else if (retireCount == 0 && afterReset != 5) begin
        otherErrors++;
        $display("first retire came %0d cycles after reset instead of 5", afterReset);
      end
      if (expected.size() == 0) begin
        otherErrors++;
        $display("extra retire to x%0d at %0t with nothing left to expect", retire.rd, $time);
      end else begin
        want = expected.pop_front();
        if (retire.rd !== want.rd) begin
          valueErrors++;
          $display("** Error retire.rd at %0t: expected %h, got %h", $time, want.rd, retire.rd);
        end
        if (retire.value !== want.value) begin
          valueErrors++;
          $display("** Error retire.value for x%0d at %0t: expected %h, got %h",
                   want.rd, $time, want.value, retire.value);
        end
      end
      retireCount++;
    end else if (!RESET && retire.valid !== 1'b0) begin
      otherErrors++;
      $display("retire.valid is unknown at %0t", $time);
    end
  end

  initial begin
    #(watchdogCycles * clkPeriod);
    otherErrors++;
    $display("run timed out after %0d cycles before all writes retired", watchdogCycles);
    finishRun();
  end

endmodule

/* tb/rvPipeline_assertions.sv */
module rvPipelineAssertions (
  input logic                   CLK,
  input logic                   RESET,
  input logic [rvPkg::xlen-1:0] fetchAddr,
  input rvPkg::retireT          retire
);
  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;

  // retire register settles one edge into reset
  quietInReset: assert property (@(posedge CLK) RESET && $past(RESET) |-> !retire.valid)
    else begin
      failCount++;
      $error("retire.valid high while RESET is held");
    end

  noZeroRetire: assert property (@(posedge CLK) !RESET && retire.valid |-> retire.rd != '0)
    else begin
      failCount++;
      $error("retire strobe reports a write to x0");
    end

  alignedFetch: assert property (@(posedge CLK) !RESET |-> fetchAddr[1:0] == 2'b00)
    else begin
      failCount++;
      $error("fetchAddr %h is not word aligned", fetchAddr);
    end

endmodule

bind rvPipelineTop rvPipelineAssertions checks (
  .CLK       (CLK),
  .RESET     (RESET),
  .fetchAddr (fetchAddr),
  .retire    (retire)
);

/* src/rvPipelineTop.sv */
module rvPipelineTop (
  input  logic                   CLK,
  input  logic                   RESET,
  input  rvPkg::instrT           fetchInstr,
  output logic [rvPkg::xlen-1:0] fetchAddr,
  output rvPkg::retireT          retire
);

  rvPkg::hazardT                  hazard;
  rvPkg::instrT                   instrDec;
  logic [rvPkg::xlen-1:0]         pcDec;
  logic [rvPkg::xlen-1:0]         pcPlus4Dec;
  logic [rvPkg::regAddrWidth-1:0] rs1Dec;
  logic [rvPkg::regAddrWidth-1:0] rs2Dec;
  rvPkg::decExT                   decEx;
  rvPkg::exMemT                   exMem;
  logic                           redirect;
  logic [rvPkg::xlen-1:0]         redirectTarget;

  // ============================================================
  // pipeline stages
  // ============================================================
  fetchStage fetch (
    .CLK(CLK), .RESET(RESET), .hazard(hazard),
    .redirect(redirect), .redirectTarget(redirectTarget),
    .fetchInstr(fetchInstr), .fetchAddr(fetchAddr),
    .instrDec(instrDec), .pcDec(pcDec), .pcPlus4Dec(pcPlus4Dec)
  );

  decodeStage decode (
    .CLK(CLK), .RESET(RESET), .hazard(hazard),
    .instrDec(instrDec), .pcDec(pcDec), .pcPlus4Dec(pcPlus4Dec),
    .retire(retire), .rs1Dec(rs1Dec), .rs2Dec(rs2Dec), .decEx(decEx)
  );

  executeStage execute (
    .CLK(CLK), .RESET(RESET), .decEx(decEx), .hazard(hazard), .retire(retire),
    .exMem(exMem), .redirect(redirect), .redirectTarget(redirectTarget)
  );

  memWriteback memWb (
    .CLK(CLK), .RESET(RESET), .exMem(exMem), .retire(retire)
  );

  hazardUnit hazards (
    .rs1Dec(rs1Dec), .rs2Dec(rs2Dec), .decEx(decEx), .exMem(exMem),
    .retire(retire), .redirect(redirect), .hazard(hazard)
  );

endmodule

/* src/hazardUnit.sv */
module hazardUnit (
  input  logic [rvPkg::regAddrWidth-1:0] rs1Dec,
  input  logic [rvPkg::regAddrWidth-1:0] rs2Dec,
  input  rvPkg::decExT                   decEx,
  input  rvPkg::exMemT                   exMem,
  input  rvPkg::retireT                  retire,
  input  logic                           redirect,
  output rvPkg::hazardT                  hazard
);

  logic loadStall;

  // memory stage is younger, so it wins over writeback
  function automatic logic [1:0] fwdSelect(input logic [rvPkg::regAddrWidth-1:0] rs,
                                           input rvPkg::exMemT m, input rvPkg::retireT w);
    if (m.regWrite && (m.rd == rs)) return rvPkg::fwdMem;
    if (w.valid && (w.rd == rs)) return rvPkg::fwdWb;
    return rvPkg::fwdNone;
  endfunction

  // load in execute feeding the instruction in decode
  assign loadStall = decEx.ctrl.regWrite && (decEx.ctrl.resultSrc == rvPkg::resMem) &&
                     ((decEx.rd == rs1Dec) || (decEx.rd == rs2Dec));

  assign hazard.stallFetch   = loadStall;
  assign hazard.stallDecode  = loadStall;
  assign hazard.flushDecode  = redirect;
  assign hazard.flushExecute = redirect || loadStall;
  assign hazard.forwardA     = fwdSelect(decEx.rs1, exMem, retire);
  assign hazard.forwardB     = fwdSelect(decEx.rs2, exMem, retire);

endmodule

/* src/memWriteback.sv */
module memWriteback (
  input  logic          CLK,
  input  logic          RESET,
  input  rvPkg::exMemT  exMem,
  output rvPkg::retireT retire
);

  logic [rvPkg::xlen-1:0]            dataMem [rvPkg::dataMemWords];
  logic [rvPkg::dataMemIdxWidth-1:0] wordIdx;
  logic [rvPkg::xlen-1:0]            readData;
  logic [rvPkg::xlen-1:0]            result;

  assign wordIdx  = exMem.aluResult[2 +: rvPkg::dataMemIdxWidth]; // byte offset dropped
  assign readData = dataMem[wordIdx];

  always_ff @(posedge CLK) begin
    if (exMem.memWrite) dataMem[wordIdx] <= exMem.storeData;
  end

  always_comb begin
    case (exMem.resultSrc)
      rvPkg::resMem: result = readData;
      rvPkg::resPc4: result = exMem.pcPlus4; // jal link
      default:       result = exMem.aluResult;
    endcase
  end

  // ============================================================
  // memory/writeback register, seen outside as retire
  // ============================================================
  always_ff @(posedge CLK) begin
    if (RESET) begin
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= exMem.regWrite;
    end
    retire.rd    <= exMem.rd;
    retire.value <= result;
  end

endmodule

/* src/executeStage.sv */
module executeStage (
  input  logic                   CLK,
  input  logic                   RESET,
  input  rvPkg::decExT           decEx,
  input  rvPkg::hazardT          hazard,
  input  rvPkg::retireT          retire,
  output rvPkg::exMemT           exMem,
  output logic                   redirect,
  output logic [rvPkg::xlen-1:0] redirectTarget
);

  logic [rvPkg::xlen-1:0] srcA;
  logic [rvPkg::xlen-1:0] fwdB;
  logic [rvPkg::xlen-1:0] srcB;
  logic [rvPkg::xlen-1:0] aluResult;
  logic [4:0]             shamt;
  rvPkg::exMemT           exMemNext;

  function automatic logic [rvPkg::xlen-1:0] pickOperand(input logic [1:0] sel,
      input logic [rvPkg::xlen-1:0] regData, input logic [rvPkg::xlen-1:0] memValue,
      input logic [rvPkg::xlen-1:0] wbValue);
    case (sel)
      rvPkg::fwdMem: return memValue;
      rvPkg::fwdWb:  return wbValue;
      default:       return regData;
    endcase
  endfunction

  // ============================================================
  // operand select and alu
  // ============================================================
  assign srcA  = pickOperand(hazard.forwardA, decEx.rs1Data, exMem.aluResult, retire.value);
  assign fwdB  = pickOperand(hazard.forwardB, decEx.rs2Data, exMem.aluResult, retire.value);
  assign srcB  = decEx.ctrl.aluSrcImm ? decEx.imm : fwdB;
  assign shamt = srcB[4:0];

  always_comb begin
    case (decEx.ctrl.aluOp)
      rvPkg::aluAdd:  aluResult = srcA + srcB;
      rvPkg::aluSub:  aluResult = srcA - srcB;
      rvPkg::aluAnd:  aluResult = srcA & srcB;
      rvPkg::aluOr:   aluResult = srcA | srcB;
      rvPkg::aluXor:  aluResult = srcA ^ srcB;
      rvPkg::aluSlt:  aluResult = rvPkg::xlen'($signed(srcA) < $signed(srcB));
      rvPkg::aluSltu: aluResult = rvPkg::xlen'(srcA < srcB);
      rvPkg::aluSll:  aluResult = srcA << shamt;
      rvPkg::aluSrl:  aluResult = srcA >> shamt;
      rvPkg::aluSra:  aluResult = $signed(srcA) >>> shamt;
      default:        aluResult = '0;
    endcase
  end

  // beq compares through the subtraction
  assign redirect       = decEx.ctrl.jump || (decEx.ctrl.branch && (aluResult == '0));
  assign redirectTarget = decEx.pc + decEx.imm;

  always_comb begin
    exMemNext.aluResult = aluResult;
    exMemNext.storeData = fwdB;         // forwarded rs2, before imm mux
    exMemNext.pcPlus4   = decEx.pcPlus4;
    exMemNext.rd        = decEx.rd;
    exMemNext.regWrite  = decEx.ctrl.regWrite;
    exMemNext.memWrite  = decEx.ctrl.memWrite;
    exMemNext.resultSrc = decEx.ctrl.resultSrc;
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      exMem.regWrite <= 1'b0;
      exMem.memWrite <= 1'b0;
    end else begin
      exMem <= exMemNext;
    end
  end

endmodule

/* src/decodeStage.sv */
module decodeStage (
  input  logic                           CLK,
  input  logic                           RESET,
  input  rvPkg::hazardT                  hazard,
  input  rvPkg::instrT                   instrDec,
  input  logic [rvPkg::xlen-1:0]         pcDec,
  input  logic [rvPkg::xlen-1:0]         pcPlus4Dec,
  input  rvPkg::retireT                  retire,
  output logic [rvPkg::regAddrWidth-1:0] rs1Dec,
  output logic [rvPkg::regAddrWidth-1:0] rs2Dec,
  output rvPkg::decExT                   decEx
);

  rvPkg::ctrlT            ctrl;
  logic [rvPkg::xlen-1:0] imm;
  logic [rvPkg::xlen-1:0] rs1Data;
  logic [rvPkg::xlen-1:0] rs2Data;
  logic                   useRs1;
  logic                   useRs2;
  logic                   writesRd;

  // funct3 map shared by op and op-imm
  function automatic rvPkg::aluOpT aluFromFunct(input logic [2:0] funct3,
                                                input logic alt, input logic isRegOp);
    rvPkg::aluOpT op;
    case (funct3)
      3'b000:  op = (isRegOp && alt) ? rvPkg::aluSub : rvPkg::aluAdd;
      3'b001:  op = rvPkg::aluSll;
      3'b010:  op = rvPkg::aluSlt;
      3'b011:  op = rvPkg::aluSltu;
      3'b100:  op = rvPkg::aluXor;
      3'b101:  op = alt ? rvPkg::aluSra : rvPkg::aluSrl; // funct7 bit 5
      3'b110:  op = rvPkg::aluOr;
      default: op = rvPkg::aluAnd;
    endcase
    return op;
  endfunction

  // ============================================================
  // control and immediate decode
  // ============================================================
  always_comb begin
    ctrl     = '0;
    imm      = '0;
    useRs1   = 1'b0;
    useRs2   = 1'b0;
    writesRd = 1'b0;
    case (instrDec.r.opcode)
      rvPkg::opOp: begin
        writesRd   = 1'b1;
        useRs1     = 1'b1;
        useRs2     = 1'b1;
        ctrl.aluOp = aluFromFunct(instrDec.r.funct3, instrDec.r.funct7[5], 1'b1);
      end
      rvPkg::opOpImm: begin
        writesRd       = 1'b1;
        useRs1         = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.aluOp     = aluFromFunct(instrDec.r.funct3, instrDec.r.funct7[5], 1'b0);
        imm            = {{20{instrDec.i.imm[11]}}, instrDec.i.imm};
      end
      rvPkg::opLoad: begin
        writesRd       = 1'b1;
        useRs1         = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.resultSrc = rvPkg::resMem;
        imm            = {{20{instrDec.i.imm[11]}}, instrDec.i.imm};
      end
      rvPkg::opStore: begin
        useRs1         = 1'b1;
        useRs2         = 1'b1;
        ctrl.memWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        imm = {{20{instrDec.s.imm11to5[6]}}, instrDec.s.imm11to5, instrDec.s.imm4to0};
      end
      rvPkg::opLui: begin
        writesRd       = 1'b1; // rs1 stays x0, so alu gives 0 + imm
        ctrl.aluSrcImm = 1'b1;
        imm            = {instrDec.u.imm31to12, 12'b0};
      end
      rvPkg::opBranch: begin
        useRs1      = 1'b1;
        useRs2      = 1'b1;
        ctrl.branch = (instrDec.b.funct3 == 3'b000); // beq only
        ctrl.aluOp  = rvPkg::aluSub;
        imm = {{19{instrDec.b.imm12}}, instrDec.b.imm12, instrDec.b.imm11,
               instrDec.b.imm10to5, instrDec.b.imm4to1, 1'b0};
      end
      rvPkg::opJal: begin
        writesRd       = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.resultSrc = rvPkg::resPc4;
        imm = {{11{instrDec.j.imm20}}, instrDec.j.imm20, instrDec.j.imm19to12,
               instrDec.j.imm11, instrDec.j.imm10to1, 1'b0};
      end
      default: ;
    endcase
    // x0 destination never writes anywhere downstream
    ctrl.regWrite = writesRd && (instrDec.r.rd != '0);
  end

  assign rs1Dec = useRs1 ? instrDec.r.rs1 : '0;
  assign rs2Dec = useRs2 ? instrDec.r.rs2 : '0;

  regFile regs (
    .CLK     (CLK),
    .rs1     (rs1Dec),
    .rs2     (rs2Dec),
    .retire  (retire),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data)
  );

  // decode/execute register
  always_ff @(posedge CLK) begin
    if (RESET || hazard.flushExecute) begin
      decEx <= '0;
    end else begin
      decEx <= '{pc:      pcDec,
                 pcPlus4: pcPlus4Dec,
                 rs1Data: rs1Data,
                 rs2Data: rs2Data,
                 imm:     imm,
                 rs1:     rs1Dec,
                 rs2:     rs2Dec,
                 rd:      instrDec.r.rd,
                 ctrl:    ctrl};
    end
  end

endmodule

/* src/fetchStage.sv */
module fetchStage (
  input  logic                   CLK,
  input  logic                   RESET,
  input  rvPkg::hazardT          hazard,
  input  logic                   redirect,
  input  logic [rvPkg::xlen-1:0] redirectTarget,
  input  rvPkg::instrT           fetchInstr,
  output logic [rvPkg::xlen-1:0] fetchAddr,
  output rvPkg::instrT           instrDec,
  output logic [rvPkg::xlen-1:0] pcDec,
  output logic [rvPkg::xlen-1:0] pcPlus4Dec
);

  logic [rvPkg::xlen-1:0] pc;
  logic [rvPkg::xlen-1:0] pcPlus4;

  assign pcPlus4   = pc + rvPkg::xlen'(4);
  assign fetchAddr = pc;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirectTarget; // taken beq or jal from execute
    end else if (!hazard.stallFetch) begin
      pc <= pcPlus4;
    end
  end

  // fetch/decode register, all-zero word decodes as a bubble
  always_ff @(posedge CLK) begin
    if (RESET || hazard.flushDecode) begin
      instrDec <= '0;
    end else if (!hazard.stallDecode) begin
      instrDec   <= fetchInstr;
      pcDec      <= pc;
      pcPlus4Dec <= pcPlus4;
    end
  end

endmodule

/* src/regFile.sv */
module regFile (
  input  logic                           CLK,
  input  logic [rvPkg::regAddrWidth-1:0] rs1,
  input  logic [rvPkg::regAddrWidth-1:0] rs2,
  input  rvPkg::retireT                  retire,
  output logic [rvPkg::xlen-1:0]         rs1Data,
  output logic [rvPkg::xlen-1:0]         rs2Data
);

  logic [rvPkg::xlen-1:0] regs [1:2**rvPkg::regAddrWidth-1]; // x0 has no storage

  // a write in the same cycle is passed straight through
  function automatic logic [rvPkg::xlen-1:0] readPort(input logic [rvPkg::regAddrWidth-1:0] addr);
    if (addr == '0) begin
      return '0;
    end else if (retire.valid && (retire.rd == addr)) begin
      return retire.value;
    end
    return regs[addr];
  endfunction

  always_comb rs1Data = readPort(rs1);
  always_comb rs2Data = readPort(rs2);

  always_ff @(posedge CLK) begin
    if (retire.valid) regs[retire.rd] <= retire.value;
  end

endmodule

/* src/rvPkg.sv */
package rvPkg;

  // ============================================================
  // widths and sizes
  // ============================================================
  localparam int xlen            = 32;
  localparam int regAddrWidth    = 5;
  localparam int dataMemWords    = 128;
  localparam int dataMemIdxWidth = $clog2(dataMemWords);

  // opcodes kept from RV32I
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;

  // execute operand source
  localparam logic [1:0] fwdNone = 2'b00; // register file data
  localparam logic [1:0] fwdWb   = 2'b01; // writeback value
  localparam logic [1:0] fwdMem  = 2'b10; // memory stage alu result

  // upper two bits give the group: arith, logic, compare, shift
  typedef enum logic [3:0] {
    aluAdd  = 4'b0000,
    aluSub  = 4'b0001,
    aluAnd  = 4'b0100,
    aluOr   = 4'b0101,
    aluXor  = 4'b0110,
    aluSlt  = 4'b1000,
    aluSltu = 4'b1001,
    aluSrl  = 4'b1101,
    aluSll  = 4'b1110,
    aluSra  = 4'b1111
  } aluOpT;

  typedef enum logic [1:0] {
    resAlu = 2'b00,
    resMem = 2'b01,
    resPc4 = 2'b10
  } resultSrcT;

  // ============================================================
  // instruction formats
  // ============================================================
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rFormatT;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iFormatT;

  typedef struct packed {
    logic [6:0] imm11to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4to0;
    logic [6:0] opcode;
  } sFormatT;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;
    logic [6:0] opcode;
  } bFormatT;

  typedef struct packed {
    logic [19:0] imm31to12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uFormatT;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10to1;
    logic       imm11;
    logic [7:0] imm19to12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jFormatT;

  typedef union packed {
    rFormatT r;
    iFormatT i;
    sFormatT s;
    bFormatT b;
    uFormatT u;
    jFormatT j;
  } instrT;

  // ============================================================
  // stage payloads
  // ============================================================
  typedef struct packed {
    logic      regWrite;
    logic      memWrite;
    logic      jump;
    logic      branch;
    logic      aluSrcImm;
    aluOpT     aluOp;
    resultSrcT resultSrc;
  } ctrlT;

  typedef struct packed {
    logic [xlen-1:0]         pc;
    logic [xlen-1:0]         pcPlus4;
    logic [xlen-1:0]         rs1Data;
    logic [xlen-1:0]         rs2Data;
    logic [xlen-1:0]         imm;
    logic [regAddrWidth-1:0] rs1;
    logic [regAddrWidth-1:0] rs2;
    logic [regAddrWidth-1:0] rd;
    ctrlT                    ctrl;
  } decExT;

  typedef struct packed {
    logic [xlen-1:0]         aluResult;
    logic [xlen-1:0]         storeData;
    logic [xlen-1:0]         pcPlus4;
    logic [regAddrWidth-1:0] rd;
    logic                    regWrite;
    logic                    memWrite;
    resultSrcT               resultSrc;
  } exMemT;

  typedef struct packed {
    logic                    valid;
    logic [regAddrWidth-1:0] rd;
    logic [xlen-1:0]         value;
  } retireT;

  typedef struct packed {
    logic       stallFetch;
    logic       stallDecode;
    logic       flushDecode;
    logic       flushExecute;
    logic [1:0] forwardA;
    logic [1:0] forwardB;
  } hazardT;

endpackage
